// File: hdl/intr_cfg.svh
/*
 * Widths are fixed by the register-bank word layout.
 * Every width must be a whole number of register words.
 */

`ifndef INTR_CFG_SVH
`define INTR_CFG_SVH

// One register-bank word
`define INTR_REG_W 32

// Card-to-host interrupt lines
`define INTR_C2H_W 64
`define INTR_C2H_WORDS (`INTR_C2H_W / `INTR_REG_W)  // 2 words

// GPIO, same width in both directions
`define INTR_GPIO_W 256
`define INTR_GPIO_WORDS (`INTR_GPIO_W / `INTR_REG_W)  // 8 words

// Host-to-card interrupt lines
`define INTR_H2C_W 128
`define INTR_H2C_WORDS (`INTR_H2C_W / `INTR_REG_W)  // 4 words

`endif

// File: hdl/intr_pkg.sv
/*
 * Shared types for the interrupt handler and its testbench.
 * Register word 0 always sits in the low bits of a vector.
 */

`include "intr_cfg.svh"

package intr_pkg;

   // c2h lines, read per line or per register word
   typedef union packed
   {
      logic [`INTR_C2H_W-1:0] flat;                          // Edge logic view
      logic [`INTR_C2H_WORDS-1:0][`INTR_REG_W-1:0] words;   // Register-bank view
   } c2h_vec_u;

   typedef logic [`INTR_GPIO_WORDS-1:0][`INTR_REG_W-1:0] gpio_words_t;

   typedef logic [`INTR_H2C_WORDS-1:0][`INTR_REG_W-1:0] h2c_words_t;

   // Status/enable pairs of the non-c2h interrupt sources
   typedef struct packed
   {
      logic [`INTR_REG_W-1:0] err_status;
      logic [`INTR_REG_W-1:0] err_enable;
      logic [`INTR_REG_W-1:0] txn_status;   // Transaction available
      logic [`INTR_REG_W-1:0] txn_enable;
      logic [`INTR_REG_W-1:0] comp_status;  // Completion
      logic [`INTR_REG_W-1:0] comp_enable;
   } irq_src_t;

   // Acknowledge FSM states
   typedef enum logic [1:0]
   {
      IDLE       = 2'b00,
      ASSERT     = 2'b01,
      WAIT_CLEAR = 2'b10,
      DEASSERT   = 2'b11
   } irq_state_e;

endpackage

// File: hdl/c2h_edge_status.sv
/*
 * Sticky toggle status for the c2h interrupt lines.
 * Inputs are assumed synchronous to axi_aclk.
 * An edge in the same cycle as a clear of a set bit is lost.
 */

`timescale 1ns/100ps

module c2h_edge_status
(
   input  logic               axi_aclk,
   input  logic               axi_aresetn,
   input  intr_pkg::c2h_vec_u c2h_intr_in,
   input  intr_pkg::c2h_vec_u toggle_clear,
   output intr_pkg::c2h_vec_u toggle_status
);

   intr_pkg::c2h_vec_u c2h_q;       // Last sampled line levels
   intr_pkg::c2h_vec_u edge_pulse;  // Rising or falling edge seen this cycle

   // Registered copy of the lines
   always_ff @(posedge axi_aclk)
   begin
      if (!axi_aresetn)
      begin
         c2h_q <= '0;
      end
      else
      begin
         c2h_q <= c2h_intr_in;
      end
   end

   // Either edge direction counts
   always_comb
   begin
      edge_pulse.flat = c2h_intr_in.flat ^ c2h_q.flat;
   end

   /*
    * A status bit loads the edge pulse while it is 0,
    * otherwise it holds until software writes the clear
    */
   always_ff @(posedge axi_aclk)
   begin
      if (!axi_aresetn)
      begin
         toggle_status <= '0;
      end
      else
      begin
         for (int i = 0; i < $bits(toggle_status); i++)
         begin
            if (!toggle_status.flat[i])
            begin
               toggle_status.flat[i] <= edge_pulse.flat[i];  // Wait for an edge
            end
            else if (toggle_clear.flat[i])
            begin
               toggle_status.flat[i] <= 1'b0;               // Clear wins over a new edge
            end
            else
            begin
               toggle_status.flat[i] <= 1'b1;
            end
         end
      end
   end

endmodule

// File: hdl/io_sampler.sv
/*
 * Register-bank snapshots of the c2h levels and GPIO inputs.
 * h2c_gpio_out follows h2c_gpio_words with no register.
 */

`timescale 1ns/100ps

module io_sampler
(
   input  logic                  axi_aclk,
   input  logic                  axi_aresetn,
   input  intr_pkg::c2h_vec_u    c2h_intr_in,
   input  intr_pkg::gpio_words_t c2h_gpio_in,
   input  intr_pkg::h2c_words_t  h2c_intr_words,
   input  intr_pkg::gpio_words_t h2c_gpio_words,
   output intr_pkg::c2h_vec_u    level_status,
   output intr_pkg::gpio_words_t gpio_status,
   output intr_pkg::h2c_words_t  h2c_intr_out,
   output intr_pkg::gpio_words_t h2c_gpio_out
);

   // One-cycle sampling towards the register bank and the card
   always_ff @(posedge axi_aclk)
   begin
      if (!axi_aresetn)
      begin
         level_status <= '0;
         gpio_status  <= '0;
         h2c_intr_out <= '0;
      end
      else
      begin
         level_status.words <= c2h_intr_in.words;  // Level status per register word
         gpio_status        <= c2h_gpio_in;
         h2c_intr_out       <= h2c_intr_words;     // Host-written lines to the card
      end
   end

   // Host GPIO words drive the card pins directly
   assign h2c_gpio_out = h2c_gpio_words;

endmodule

// File: hdl/irq_ack_fsm.sv
/*
 * Four-phase irq_out/irq_ack handshake to the host.
 * A new request waits until the host has dropped irq_ack.
 * If the host never acknowledges, irq_out stays high.
 */

`timescale 1ns/100ps

module irq_ack_fsm
(
   input  logic               axi_aclk,
   input  logic               axi_aresetn,
   input  intr_pkg::c2h_vec_u toggle_status,
   input  intr_pkg::c2h_vec_u toggle_enable,
   input  intr_pkg::irq_src_t irq_src,
   input  logic               irq_ack,
   output logic               irq_out
);

   intr_pkg::irq_state_e state;
   intr_pkg::irq_state_e next_state;
   logic                 pending;  // Any enabled source is set

   // OR of the four masked sources
   always_comb
   begin
      pending = (|(toggle_status.flat & toggle_enable.flat))
              | (|(irq_src.err_status & irq_src.err_enable))
              | (|(irq_src.txn_status & irq_src.txn_enable))
              | (|(irq_src.comp_status & irq_src.comp_enable));
   end

   always_comb
   begin
      next_state = state;
      unique case (state)
         intr_pkg::IDLE:
         begin
            if (pending)
            begin
               next_state = intr_pkg::ASSERT;
            end
         end
         intr_pkg::ASSERT:
         begin
            if (irq_ack)
            begin
               next_state = intr_pkg::WAIT_CLEAR;  // Host has seen the request
            end
         end
         intr_pkg::WAIT_CLEAR:
         begin
            if (!pending)
            begin
               next_state = intr_pkg::DEASSERT;    // Software serviced all sources
            end
         end
         intr_pkg::DEASSERT:
         begin
            if (!irq_ack)
            begin
               next_state = intr_pkg::IDLE;
            end
         end
         default:
         begin
            next_state = intr_pkg::IDLE;
         end
      endcase
   end

   // irq_out is decoded from the next state so it moves with the state register
   always_ff @(posedge axi_aclk)
   begin
      if (!axi_aresetn)
      begin
         state   <= intr_pkg::IDLE;
         irq_out <= 1'b0;
      end
      else
      begin
         state   <= next_state;
         irq_out <= (next_state == intr_pkg::ASSERT) || (next_state == intr_pkg::WAIT_CLEAR);
      end
   end

endmodule

// File: hdl/intr_handler.sv
/*
 * Interrupt and GPIO handler, top level.
 * All register-bank words are 32 bits with word 0 in the low bits.
 */

`timescale 1ns/100ps

module intr_handler
(
   input  logic                  axi_aclk,
   input  logic                  axi_aresetn,
   input  intr_pkg::c2h_vec_u    c2h_intr_in,
   input  intr_pkg::gpio_words_t c2h_gpio_in,
   input  intr_pkg::h2c_words_t  h2c_intr_words,
   input  intr_pkg::gpio_words_t h2c_gpio_words,
   input  intr_pkg::c2h_vec_u    toggle_clear,
   input  intr_pkg::c2h_vec_u    toggle_enable,
   input  intr_pkg::irq_src_t    irq_src,
   input  logic                  irq_ack,
   output logic                  irq_out,
   output intr_pkg::c2h_vec_u    toggle_status,
   output intr_pkg::c2h_vec_u    level_status,
   output intr_pkg::gpio_words_t gpio_status,
   output intr_pkg::h2c_words_t  h2c_intr_out,
   output intr_pkg::gpio_words_t h2c_gpio_out
);

   // Sticky edge status, also feeds the interrupt request
   c2h_edge_status c2h_edge_status_inst
   (
      .axi_aclk      (axi_aclk),
      .axi_aresetn   (axi_aresetn),
      .c2h_intr_in   (c2h_intr_in),
      .toggle_clear  (toggle_clear),
      .toggle_status (toggle_status)
   );

   io_sampler io_sampler_inst
   (
      .axi_aclk       (axi_aclk),
      .axi_aresetn    (axi_aresetn),
      .c2h_intr_in    (c2h_intr_in),
      .c2h_gpio_in    (c2h_gpio_in),
      .h2c_intr_words (h2c_intr_words),
      .h2c_gpio_words (h2c_gpio_words),
      .level_status   (level_status),
      .gpio_status    (gpio_status),
      .h2c_intr_out   (h2c_intr_out),
      .h2c_gpio_out   (h2c_gpio_out)
   );

   // Host interrupt request and acknowledge
   irq_ack_fsm irq_ack_fsm_inst
   (
      .axi_aclk      (axi_aclk),
      .axi_aresetn   (axi_aresetn),
      .toggle_status (toggle_status),
      .toggle_enable (toggle_enable),
      .irq_src       (irq_src),
      .irq_ack       (irq_ack),
      .irq_out       (irq_out)
   );

endmodule

// File: verif/intr_handler_asserts.sv
/*
 * Checks on the irq request FSM and the sticky toggle status.
 * Bound to both modules; each bind ties the ports it does not use to constants.
 */

`timescale 1ns/100ps

module intr_handler_asserts
(
   input logic                 axi_aclk,
   input logic                 axi_aresetn,
   input intr_pkg::irq_state_e state,
   input logic                 pending,
   input logic                 irq_out,
   input intr_pkg::c2h_vec_u   toggle_status,
   input intr_pkg::c2h_vec_u   toggle_clear
);

   // A request only starts from IDLE
   irq_rise_from_idle: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      $rose(irq_out) |-> ($past(state) == intr_pkg::IDLE) && $past(pending))
      else $error("irq_out rose without a pending request in IDLE");

   // Sticky bits drop only on a clear
   toggle_fall_needs_clear: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      ($past(toggle_status.flat) & ~toggle_status.flat & ~$past(toggle_clear.flat)) == '0)
      else $error("toggle status bit fell without its clear bit");

   irq_low_after_reset: assert property (@(posedge axi_aclk)
      !axi_aresetn |=> !irq_out)
      else $error("irq_out high in the cycle after reset");

endmodule

bind irq_ack_fsm intr_handler_asserts irq_checks
(
   .axi_aclk      (axi_aclk),
   .axi_aresetn   (axi_aresetn),
   .state         (state),
   .pending       (pending),
   .irq_out       (irq_out),
   .toggle_status ('0),
   .toggle_clear  ('0)
);

bind c2h_edge_status intr_handler_asserts toggle_checks
(
   .axi_aclk      (axi_aclk),
   .axi_aresetn   (axi_aresetn),
   .state         (intr_pkg::IDLE),
   .pending       (1'b0),
   .irq_out       (1'b0),
   .toggle_status (toggle_status),
   .toggle_clear  (toggle_clear)
);

// File: verif/intr_handler_tb.sv
/*
 * Testbench for the interrupt handler top level.
 * Run from the project root so the golden file path resolves.
 * Golden steps hold only the c2h toggle and level status.
 */

`timescale 1ns/100ps

`include "intr_cfg.svh"

module intr_handler_tb;

   localparam int NUM_STEPS   = 20;                       // Lines in the golden file
   localparam int WATCHDOG_NS = (NUM_STEPS + 200) * 10;

   logic                  axi_aclk;
   logic                  axi_aresetn;
   intr_pkg::c2h_vec_u    c2h_intr_in;
   intr_pkg::gpio_words_t c2h_gpio_in;
   intr_pkg::h2c_words_t  h2c_intr_words;
   intr_pkg::gpio_words_t h2c_gpio_words;
   intr_pkg::c2h_vec_u    toggle_clear;
   intr_pkg::c2h_vec_u    toggle_enable;
   intr_pkg::irq_src_t    irq_src;
   logic                  irq_ack;
   logic                  irq_out;
   intr_pkg::c2h_vec_u    toggle_status;
   intr_pkg::c2h_vec_u    level_status;
   intr_pkg::gpio_words_t gpio_status;
   intr_pkg::h2c_words_t  h2c_intr_out;
   intr_pkg::gpio_words_t h2c_gpio_out;

   // Four words per step: input, clear, expected toggle, expected level
   logic [`INTR_C2H_W-1:0] golden_mem [0:4*NUM_STEPS-1];
   int                     error_count;
   int                     check_count;

   intr_handler intr_handler_inst
   (
      .axi_aclk       (axi_aclk),
      .axi_aresetn    (axi_aresetn),
      .c2h_intr_in    (c2h_intr_in),
      .c2h_gpio_in    (c2h_gpio_in),
      .h2c_intr_words (h2c_intr_words),
      .h2c_gpio_words (h2c_gpio_words),
      .toggle_clear   (toggle_clear),
      .toggle_enable  (toggle_enable),
      .irq_src        (irq_src),
      .irq_ack        (irq_ack),
      .irq_out        (irq_out),
      .toggle_status  (toggle_status),
      .level_status   (level_status),
      .gpio_status    (gpio_status),
      .h2c_intr_out   (h2c_intr_out),
      .h2c_gpio_out   (h2c_gpio_out)
   );

   always #5 axi_aclk = ~axi_aclk;  // 10 ns period

   task automatic report_mismatch(input string msg);
      error_count++;
      $display("Fail at %0t: %s", $time, msg);
   endtask

   // Inputs change 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge axi_aclk);
      #1;
   endtask

   task automatic expect_irq(input logic level, input string when);
      check_count++;
      if (irq_out !== level)
      begin
         report_mismatch($sformatf("irq_out is %b, expected %b (%s)", irq_out, level, when));
      end
   endtask

   // Source 0 is the c2h toggle status, set by an edge on the lines
   task automatic drive_source(input int src, input logic [31:0] status,
                               input logic [31:0] enable);
      case (src)
         0:
         begin
            toggle_enable.words[0] = enable;
            if (status != 32'h0)
            begin
               c2h_intr_in.words[0] = c2h_intr_in.words[0] ^ status;
            end
            else
            begin
               toggle_clear.words[0] = '1;  // Held for one cycle by the caller
            end
         end
         1:
         begin
            irq_src.err_status = status;
            irq_src.err_enable = enable;
         end
         2:
         begin
            irq_src.txn_status = status;
            irq_src.txn_enable = enable;
         end
         default:
         begin
            irq_src.comp_status = status;
            irq_src.comp_enable = enable;
         end
      endcase
   endtask

   task automatic run_golden();
      for (int i = 0; i < NUM_STEPS; i++)
      begin
         c2h_intr_in.flat  = golden_mem[4*i];
         toggle_clear.flat = golden_mem[4*i+1];
         next_cycle();
         check_count += 2;
         if (toggle_status.flat !== golden_mem[4*i+2])
         begin
            report_mismatch($sformatf("step %0d toggle_status %h, expected %h",
                                      i, toggle_status.flat, golden_mem[4*i+2]));
         end
         if (level_status.flat !== golden_mem[4*i+3])
         begin
            report_mismatch($sformatf("step %0d level_status %h, expected %h",
                                      i, level_status.flat, golden_mem[4*i+3]));
         end
      end
      toggle_clear.flat = '1;  // Start the irq tests with no toggle bit set
      next_cycle();
      toggle_clear.flat = '0;
   endtask

   task automatic run_gpio();
      intr_pkg::gpio_words_t exp_gpio;
      intr_pkg::h2c_words_t  exp_h2c;
      for (int r = 0; r < 4; r++)
      begin
         for (int w = 0; w < `INTR_GPIO_WORDS; w++)
         begin
            c2h_gpio_in[w]    = $urandom;
            h2c_gpio_words[w] = $urandom;
         end
         for (int w = 0; w < `INTR_H2C_WORDS; w++)
         begin
            h2c_intr_words[w] = $urandom;
         end
         exp_gpio = c2h_gpio_in;
         exp_h2c  = h2c_intr_words;
         #1;
         check_count++;
         if (h2c_gpio_out !== h2c_gpio_words)
         begin
            report_mismatch($sformatf("round %0d h2c_gpio_out differs from h2c_gpio_words", r));
         end
         next_cycle();
         check_count += 2;
         if (gpio_status !== exp_gpio)
         begin
            report_mismatch($sformatf("round %0d gpio_status %h, expected %h",
                                      r, gpio_status, exp_gpio));
         end
         if (h2c_intr_out !== exp_h2c)
         begin
            report_mismatch($sformatf("round %0d h2c_intr_out %h, expected %h",
                                      r, h2c_intr_out, exp_h2c));
         end
      end
   endtask

   task automatic run_source(input int src);
      drive_source(src, 32'h0000_0020, 32'h0);  // Set but masked
      repeat (20)
      begin
         next_cycle();
         expect_irq(1'b0, $sformatf("source %0d masked", src));
      end
      drive_source(src, 32'h0000_0020, 32'h0000_0020);
      next_cycle();
      expect_irq(1'b1, $sformatf("source %0d enabled", src));
      irq_ack = 1'b1;
      drive_source(src, 32'h0, 32'h0);
      next_cycle();
      toggle_clear.flat = '0;
      expect_irq(1'b1, $sformatf("source %0d acknowledged", src));
      next_cycle();
      expect_irq(1'b0, $sformatf("source %0d cleared", src));
      irq_ack = 1'b0;
      next_cycle();
   endtask

   task automatic run_handshake();
      drive_source(1, 32'h1, 32'h1);
      next_cycle();
      expect_irq(1'b1, "request raised");
      repeat (10)
      begin
         next_cycle();
         expect_irq(1'b1, "no acknowledge yet");
      end
      drive_source(1, 32'h0, 32'h1);  // Serviced before the host acknowledges
      repeat (3)
      begin
         next_cycle();
         expect_irq(1'b1, "source cleared, no acknowledge yet");
      end
      drive_source(1, 32'h1, 32'h1);
      irq_ack = 1'b1;
      repeat (5)
      begin
         next_cycle();
         expect_irq(1'b1, "acknowledged with source still set");
      end
      drive_source(1, 32'h0, 32'h1);
      next_cycle();
      expect_irq(1'b0, "source cleared");
      drive_source(1, 32'h1, 32'h1);  // New event while irq_ack is still high
      repeat (10)
      begin
         next_cycle();
         expect_irq(1'b0, "irq_ack still high");
      end
      irq_ack = 1'b0;
      next_cycle();
      expect_irq(1'b0, "back in idle");
      next_cycle();
      expect_irq(1'b1, "second request");
      irq_ack = 1'b1;
      drive_source(1, 32'h0, 32'h0);
      next_cycle();
      next_cycle();
      expect_irq(1'b0, "second request serviced");
      irq_ack = 1'b0;
      next_cycle();
   endtask

   initial
   begin
      error_count    = 0;
      check_count    = 0;
      axi_aclk       = 1'b0;
      axi_aresetn    = 1'b0;
      c2h_intr_in    = '0;
      c2h_gpio_in    = '0;
      h2c_intr_words = '0;
      h2c_gpio_words = '0;
      toggle_clear   = '0;
      toggle_enable  = '0;
      irq_src        = '0;
      irq_ack        = 1'b0;
      void'($urandom(32'h4ecc));
      $readmemh("verif/intr_golden.txt", golden_mem);
      repeat (5) @(posedge axi_aclk);
      #1;
      axi_aresetn = 1'b1;
      check_count++;
      if (irq_out !== 1'b0 || toggle_status.flat !== '0 || level_status.flat !== '0 ||
          gpio_status !== '0 || h2c_intr_out !== '0)
      begin
         report_mismatch("outputs not all zero after reset");
      end
      run_golden();
      run_gpio();
      for (int src = 0; src < 4; src++)
      begin
         run_source(src);
      end
      run_handshake();
      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
      begin
         $display("TEST OK");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Watchdog
   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// File: verif/intr_golden.txt
// Columns: c2h_intr_in, toggle_clear, expected toggle_status, expected level_status
// Expected values hold after the rising edge that follows each step
// Steps cover rising and falling edges, stickiness, clear and an edge lost to a clear
0000000000000001 0000000000000000 0000000000000001 0000000000000001
0000000000000001 0000000000000000 0000000000000001 0000000000000001
0000000000000000 0000000000000000 0000000000000001 0000000000000000
0000000000000000 0000000000000001 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000001 0000000000000000 0000000000000001 0000000000000001
0000000000000001 0000000000000001 0000000000000000 0000000000000001
0000000000000000 0000000000000000 0000000000000001 0000000000000000
0000000000000002 0000000000000001 0000000000000002 0000000000000002
0000000000000000 0000000000000002 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
8000000000000000 0000000000000000 8000000000000000 8000000000000000
8000000100000000 0000000000000000 8000000100000000 8000000100000000
0000000100000000 8000000000000000 0000000100000000 0000000100000000
0000000100000000 0000000100000000 0000000000000000 0000000100000000
F0F0F0F0A5A5A5A5 0000000000000000 F0F0F0F1A5A5A5A5 F0F0F0F0A5A5A5A5
F0F0F0F0A5A5A5A5 FFFFFFFF00000000 00000000A5A5A5A5 F0F0F0F0A5A5A5A5
0F0F0F0F5A5A5A5A 00000000FFFFFFFF FFFFFFFF5A5A5A5A 0F0F0F0F5A5A5A5A
0F0F0F0F5A5A5A5A FFFFFFFFFFFFFFFF 0000000000000000 0F0F0F0F5A5A5A5A
0000000000000000 0000000000000000 0F0F0F0F5A5A5A5A 0000000000000000

// File: sources.f
+incdir+hdl
hdl/intr_pkg.sv
hdl/c2h_edge_status.sv
hdl/io_sampler.sv
hdl/irq_ack_fsm.sv
hdl/intr_handler.sv
verif/intr_handler_asserts.sv
verif/intr_handler_tb.sv

// File: Makefile
# Verilator build and run of the interrupt handler testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 -Mdir obj_dir
TOP       = intr_handler_tb
FILELIST  = sources.f
LOG       = sim.log
FAIL_MSG  = TEST FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build folder and the log"

# A simulator abort, such as a failed assertion, is logged as a failure
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
